//--- include/board_config.svh
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

//----------------------------------------------------------------------------
// LCD horizontal timing, in pixel clocks

`define LCD_H_FRONT_PORCH   40
`define LCD_H_SYNC          48
`define LCD_H_BACK_PORCH    88

//----------------------------------------------------------------------------
// LCD vertical timing, in lines

`define LCD_V_FRONT_PORCH   13
`define LCD_V_SYNC          3
`define LCD_V_BACK_PORCH    32

// Both syncs are active low on this panel
`define LCD_SYNC_ACTIVE     1'b0

`endif

//--- hw/video_pkg.sv
`default_nettype none

package video_pkg;

    // Pixel column or row, wide enough for 800 x 480 plus porches
    typedef logic [10:0] coord_t;

    // Panel colour channels
    typedef logic [4:0] red_t;
    typedef logic [5:0] green_t;
    typedef logic [4:0] blue_t;

    typedef struct packed
    {
        red_t   red;
        green_t green;
        blue_t  blue;
    } rgb_t;

    // One clock of the LCD scan
    typedef struct packed
    {
        coord_t x;
        coord_t y;
        logic   de;
        logic   hs;
        logic   vs;
    } lcd_scan_t;

endpackage

`default_nettype wire

//--- hw/audio_pkg.sv
`default_nettype none

package audio_pkg;

    // Signed PCM sample, same word on both channels
    typedef logic signed [15:0] sample_t;

    // Pins of the on-board I2S amplifier
    typedef struct packed
    {
        logic bck;
        logic ws;
        logic din;
    } i2s_pins_t;

endpackage

`default_nettype wire

//--- hw/heartbeat_counter.sv
`timescale 1ns/1ns
`default_nettype none

module heartbeat_counter
#(
    parameter int clk_mhz = 27,
    parameter int slow_hz = 4,
    parameter int w_led   = 6
)
(
    input  wire               clk,
    input  wire               rst_n,
    output logic [w_led-1:0]  led
);

    localparam int period = clk_mhz * 1000000 / slow_hz;
    localparam int w_cnt  = $clog2(period + 1);

    logic [w_cnt-1:0] cnt;
    logic             tick;

    assign tick = (cnt == '0);

    // Down-counter, tick on zero then reload
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cnt <= w_cnt'(period - 1);
        else if (tick)
            cnt <= w_cnt'(period - 1);
        else
            cnt <= cnt - 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            led <= '0;
        else if (tick)
            led <= led + 1'b1;
    end

endmodule

`default_nettype wire

//--- hw/lcd_timing.sv
`timescale 1ns/1ns
`default_nettype none

`include "board_config.svh"

module lcd_timing
#(
    parameter int screen_width  = 800,
    parameter int screen_height = 480
)
(
    input  wire                   clk,
    input  wire                   rst_n,
    output video_pkg::lcd_scan_t  scan
);

    import video_pkg::*;

    localparam logic sync_on = `LCD_SYNC_ACTIVE;

    // Line layout: active, front porch, sync, back porch
    localparam int h_sync_start = screen_width + `LCD_H_FRONT_PORCH;
    localparam int h_sync_end   = h_sync_start + `LCD_H_SYNC;
    localparam int h_total      = h_sync_end + `LCD_H_BACK_PORCH;

    // Frame layout, same order in lines
    localparam int v_sync_start = screen_height + `LCD_V_FRONT_PORCH;
    localparam int v_sync_end   = v_sync_start + `LCD_V_SYNC;
    localparam int v_total      = v_sync_end + `LCD_V_BACK_PORCH;

    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_last;
    logic   v_last;
    logic   h_sync;
    logic   v_sync;

    assign h_last = (h_cnt == coord_t'(h_total - 1));
    assign v_last = (v_cnt == coord_t'(v_total - 1));

    assign h_sync = (h_cnt >= coord_t'(h_sync_start)) && (h_cnt < coord_t'(h_sync_end));
    assign v_sync = (v_cnt >= coord_t'(v_sync_start)) && (v_cnt < coord_t'(v_sync_end));

    //------------------------------------------------------------------------
    // Frame counters

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_last)
        begin
            h_cnt <= '0;

            if (v_last)
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 1'b1;
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Registered scan fields

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scan.x  <= '0;
            scan.y  <= '0;
            scan.de <= 1'b0;
            scan.hs <= ~sync_on;
            scan.vs <= ~sync_on;
        end
        else
        begin
            scan.x  <= h_cnt;
            scan.y  <= v_cnt;
            scan.de <= (h_cnt < coord_t'(screen_width)) && (v_cnt < coord_t'(screen_height));
            scan.hs <= h_sync ? sync_on : ~sync_on;
            scan.vs <= v_sync ? sync_on : ~sync_on;
        end
    end

endmodule

`default_nettype wire

//--- hw/pattern_pixel_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "board_config.svh"

module pattern_pixel_stage
#(
    parameter int screen_width  = 800,
    parameter int screen_height = 480
)
(
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire  [1:0]                 key,
    input  wire  video_pkg::lcd_scan_t scan,
    output video_pkg::lcd_scan_t       lcd_out,
    output video_pkg::rgb_t            pixel
);

    import video_pkg::*;

    localparam logic sync_on = `LCD_SYNC_ACTIVE;

    logic [1:0] key0_sync;
    logic       blue_on;
    coord_t     mx;
    coord_t     my;
    rgb_t       pixel_next;

    // Key is active low, idles high
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            key0_sync <= 2'b11;
        else
            key0_sync <= {key0_sync[0], key[0]};
    end

    assign blue_on = ~key0_sync[1];

    // Panel is mounted upside down
    assign mx = coord_t'(screen_width - 1) - scan.x;
    assign my = coord_t'(screen_height - 1) - scan.y;

    always_comb
    begin
        pixel_next       = '0;
        if (scan.de)
        begin
            pixel_next.red   = (mx < coord_t'(screen_width / 2))  ? '1 : '0;
            pixel_next.green = (my < coord_t'(screen_height / 2)) ? '1 : '0;
            pixel_next.blue  = blue_on ? '1 : '0;
        end
    end

    // One clock stage, scan fields delayed alongside the colour
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            lcd_out <= '{x: '0, y: '0, de: 1'b0, hs: ~sync_on, vs: ~sync_on};
            pixel   <= '0;
        end
        else
        begin
            lcd_out <= scan;
            pixel   <= pixel_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/tone_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tone_gen
#(
    parameter int                 tone_half_period = 24,
    parameter audio_pkg::sample_t tone_amplitude   = 16'sh2000
)
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire  [1:0]          key,
    output audio_pkg::sample_t  sample,
    output logic                sample_req,
    input  wire                 sample_ack
);

    import audio_pkg::*;

    typedef enum logic [1:0]
    {
        st_idle,
        st_request,
        st_release
    } state_t;

    localparam int      w_phase = $clog2(tone_half_period + 1);
    localparam sample_t amp_pos = tone_amplitude;
    localparam sample_t amp_neg = -tone_amplitude;

    state_t             state;
    logic [1:0]         key1_sync;
    logic               mute;
    logic [w_phase-1:0] phase;
    logic               negative;
    logic               phase_last;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            key1_sync <= 2'b11;
        else
            key1_sync <= {key1_sync[0], key[1]};
    end

    assign mute       = ~key1_sync[1];
    assign phase_last = (phase == w_phase'(tone_half_period - 1));

    //------------------------------------------------------------------------
    // Four-phase handshake, next sample only after ack drops

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= st_idle;
            sample_req <= 1'b0;
            sample     <= amp_pos;
            phase      <= '0;
            negative   <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    sample_req <= 1'b1;
                    state      <= st_request;
                end

                st_request:
                begin
                    if (sample_ack)
                    begin
                        sample_req <= 1'b0;
                        state      <= st_release;
                    end
                end

                st_release:
                begin
                    if (!sample_ack)
                    begin
                        state <= st_idle;

                        // Muted: phase holds where it was
                        if (mute)
                        begin
                            sample <= '0;
                        end
                        else if (phase_last)
                        begin
                            phase    <= '0;
                            negative <= ~negative;
                            sample   <= negative ? amp_pos : amp_neg;
                        end
                        else
                        begin
                            phase  <= phase + 1'b1;
                            sample <= negative ? amp_neg : amp_pos;
                        end
                    end
                end

                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/i2s_audio_out.sv
`timescale 1ns/1ns
`default_nettype none

module i2s_audio_out
#(
    parameter int bclk_div = 4
)
(
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire  audio_pkg::sample_t  sample,
    input  wire                       sample_req,
    output logic                      sample_ack,
    output audio_pkg::i2s_pins_t      pins
);

    import audio_pkg::*;

    localparam int w_div = $clog2(bclk_div + 1);

    logic [w_div-1:0] div_cnt;
    logic             div_wrap;
    logic             bck;
    logic             bck_fall;
    logic [4:0]       bit_cnt;
    logic [4:0]       next_bit;
    logic             frame_start;
    logic             ws;
    logic [31:0]      shift_reg;
    sample_t          pending;
    logic             pending_valid;
    logic             accept;
    sample_t          held;
    sample_t          word;

    //------------------------------------------------------------------------
    // Bit clock divider

    assign div_wrap = (div_cnt == w_div'(bclk_div - 1));
    assign bck_fall = div_wrap & bck;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            bck     <= 1'b0;
        end
        else if (div_wrap)
        begin
            div_cnt <= '0;
            bck     <= ~bck;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Frame sequencing, all updates on the falling edge of bck

    assign next_bit    = bit_cnt + 1'b1;
    assign frame_start = bck_fall && (next_bit == 5'd0);

    // No new sample this frame: repeat the last one
    assign word = pending_valid ? pending : held;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // Start in the last slot so the first fall opens a frame
            bit_cnt   <= 5'd31;
            ws        <= 1'b0;
            shift_reg <= '0;
            held      <= '0;
        end
        else if (bck_fall)
        begin
            bit_cnt <= next_bit;

            // WS leads the MSB of each channel by one bit
            ws <= (next_bit >= 5'd15) && (next_bit <= 5'd30);

            if (frame_start)
            begin
                shift_reg <= {word, word};
                held      <= word;
            end
            else
            begin
                shift_reg <= {shift_reg[30:0], 1'b0};
            end
        end
    end

    //------------------------------------------------------------------------
    // Handshake side, one sample per frame

    assign accept = sample_req && !sample_ack && !pending_valid;

    always_ff @(posedge clk)
    begin
        if (accept)
            pending <= sample;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pending_valid <= 1'b0;
            sample_ack    <= 1'b0;
        end
        else
        begin
            if (frame_start)
                pending_valid <= 1'b0;

            if (accept)
            begin
                pending_valid <= 1'b1;
                sample_ack    <= 1'b1;
            end
            else if (!sample_req && sample_ack)
            begin
                sample_ack <= 1'b0;
            end
        end
    end

    assign pins.bck = bck;
    assign pins.ws  = ws;
    assign pins.din = shift_reg[31];

endmodule

`default_nettype wire

//--- hw/board_specific_top.sv
`timescale 1ns/1ns
`default_nettype none

module board_specific_top
#(
    parameter int                 clk_mhz          = 27,
    parameter int                 slow_hz          = 4,
    parameter int                 screen_width     = 800,
    parameter int                 screen_height    = 480,
    parameter int                 tone_half_period = 24,
    parameter audio_pkg::sample_t tone_amplitude   = 16'sh2000,
    parameter int                 bclk_div         = 4,
    parameter int                 w_led            = 6
)
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire  [1:0]              key,

    output wire  [w_led-1:0]        led,

    output wire                     lcd_de,
    output wire                     lcd_hs,
    output wire                     lcd_vs,
    output wire  video_pkg::red_t   lcd_r,
    output wire  video_pkg::green_t lcd_g,
    output wire  video_pkg::blue_t  lcd_b,

    output wire                     hp_bck,
    output wire                     hp_ws,
    output wire                     hp_din
);

    import video_pkg::*;
    import audio_pkg::*;

    lcd_scan_t scan;
    lcd_scan_t lcd_out;
    rgb_t      pixel;
    sample_t   sample;
    logic      sample_req;
    logic      sample_ack;
    i2s_pins_t pins;

    heartbeat_counter
    #(
        .clk_mhz ( clk_mhz ),
        .slow_hz ( slow_hz ),
        .w_led   ( w_led   )
    )
    heartbeat_i
    (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .led   ( led   )
    );

    //------------------------------------------------------------------------
    // Video path

    lcd_timing
    #(
        .screen_width  ( screen_width  ),
        .screen_height ( screen_height )
    )
    lcd_timing_i
    (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .scan  ( scan  )
    );

    pattern_pixel_stage
    #(
        .screen_width  ( screen_width  ),
        .screen_height ( screen_height )
    )
    pixel_stage_i
    (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .key     ( key     ),
        .scan    ( scan    ),
        .lcd_out ( lcd_out ),
        .pixel   ( pixel   )
    );

    assign lcd_de = lcd_out.de;
    assign lcd_hs = lcd_out.hs;
    assign lcd_vs = lcd_out.vs;
    assign lcd_r  = pixel.red;
    assign lcd_g  = pixel.green;
    assign lcd_b  = pixel.blue;

    //------------------------------------------------------------------------
    // Audio path

    tone_gen
    #(
        .tone_half_period ( tone_half_period ),
        .tone_amplitude   ( tone_amplitude   )
    )
    tone_gen_i
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .key        ( key        ),
        .sample     ( sample     ),
        .sample_req ( sample_req ),
        .sample_ack ( sample_ack )
    );

    i2s_audio_out
    #(
        .bclk_div ( bclk_div )
    )
    i2s_out_i
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .sample     ( sample     ),
        .sample_req ( sample_req ),
        .sample_ack ( sample_ack ),
        .pins       ( pins       )
    );

    assign hp_bck = pins.bck;
    assign hp_ws  = pins.ws;
    assign hp_din = pins.din;

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock
#(
    parameter int period_ns = 4
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period_ns / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tb/board_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "board_config.svh"

module board_tb;

    import video_pkg::*;
    import audio_pkg::*;

    localparam int      clk_mhz          = 1;
    localparam int      slow_hz          = 100000;
    localparam int      screen_width     = 16;
    localparam int      screen_height    = 8;
    localparam int      tone_half_period = 3;
    localparam sample_t tone_amplitude   = 16'sh1000;
    localparam int      bclk_div         = 2;
    localparam int      w_led            = 6;

    localparam int reset_cycles = 3;
    localparam int tick_clocks  = clk_mhz * 1000000 / slow_hz;

    // Scan lengths straight from the panel header
    localparam int h_total = screen_width + `LCD_H_FRONT_PORCH + `LCD_H_SYNC
                             + `LCD_H_BACK_PORCH;
    localparam int v_total = screen_height + `LCD_V_FRONT_PORCH + `LCD_V_SYNC
                             + `LCD_V_BACK_PORCH;
    localparam int frame_clocks     = h_total * v_total;
    localparam int i2s_frame_clocks = 32 * 2 * bclk_div;

    localparam int tone_frames      = 4 * tone_half_period;
    localparam int mute_frames      = 3;
    localparam int heartbeat_cycles = 6 * tick_clocks;

    // Six LCD frames cover alignment, geometry, colour and the held blue key
    localparam int watchdog_cycles = 6 * frame_clocks + 40 * i2s_frame_clocks
                                     + heartbeat_cycles + reset_cycles + 100;

    logic             clk;
    logic             rst_n;
    logic [1:0]       key;
    logic [w_led-1:0] led;
    logic             lcd_de;
    logic             lcd_hs;
    logic             lcd_vs;
    red_t             lcd_r;
    green_t           lcd_g;
    blue_t            lcd_b;
    logic             hp_bck;
    logic             hp_ws;
    logic             hp_din;

    int               cycles_since_reset;
    logic             bck_prev;
    logic             ws_prev;
    logic [15:0]      i2s_acc;

    tb_clock
    #(
        .period_ns ( 4 )
    )
    clock_i
    (
        .clk ( clk )
    );

    board_specific_top
    #(
        .clk_mhz          ( clk_mhz          ),
        .slow_hz          ( slow_hz          ),
        .screen_width     ( screen_width     ),
        .screen_height    ( screen_height    ),
        .tone_half_period ( tone_half_period ),
        .tone_amplitude   ( tone_amplitude   ),
        .bclk_div         ( bclk_div         ),
        .w_led            ( w_led            )
    )
    dut_i
    (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .key    ( key    ),
        .led    ( led    ),
        .lcd_de ( lcd_de ),
        .lcd_hs ( lcd_hs ),
        .lcd_vs ( lcd_vs ),
        .lcd_r  ( lcd_r  ),
        .lcd_g  ( lcd_g  ),
        .lcd_b  ( lcd_b  ),
        .hp_bck ( hp_bck ),
        .hp_ws  ( hp_ws  ),
        .hp_din ( hp_din )
    );

    // Clock edges seen since reset was released
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cycles_since_reset <= 0;
        else
            cycles_since_reset <= cycles_since_reset + 1;
    end

    //------------------------------------------------------------------------
    // Reporting and checking

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
            fail_run($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                               name, expected, actual));
    endtask

    function automatic logic sync_starts(input logic prev, input logic cur);
        return (prev != `LCD_SYNC_ACTIVE) && (cur == `LCD_SYNC_ACTIVE);
    endfunction

    // Test picture drawn from the mirrored position
    function automatic rgb_t expected_pixel(input int col, input int row,
                                            input logic blue_on);
        rgb_t px;
        int   mx;
        int   my;
        px        = '0;
        mx        = screen_width - 1 - col;
        my        = screen_height - 1 - row;
        px.red    = (mx < screen_width / 2) ? '1 : '0;
        px.green  = (my < screen_height / 2) ? '1 : '0;
        px.blue   = blue_on ? '1 : '0;
        return px;
    endfunction

    task automatic check_idle_outputs(input string name);
        check_value({name, " lcd_de"}, 1'b0, lcd_de);
        check_value({name, " lcd_hs"}, !`LCD_SYNC_ACTIVE, lcd_hs);
        check_value({name, " lcd_vs"}, !`LCD_SYNC_ACTIVE, lcd_vs);
        check_value({name, " pixel"}, 16'h0, {lcd_r, lcd_g, lcd_b});
        check_value({name, " led"}, 0, led);
        check_value({name, " hp_bck"}, 1'b0, hp_bck);
        check_value({name, " hp_ws"}, 1'b0, hp_ws);
        check_value({name, " hp_din"}, 1'b0, hp_din);
    endtask

    //------------------------------------------------------------------------
    // Video helpers

    task automatic wait_vs_start();
        logic vs_q;
        logic found;
        found = 1'b0;
        vs_q  = lcd_vs;
        while (!found)
        begin
            @(negedge clk);
            found = sync_starts(vs_q, lcd_vs);
            vs_q  = lcd_vs;
        end
    endtask

    // Walks one whole frame and must be entered on a vsync start
    task automatic walk_frame(input string name, input logic check_colour,
                              input logic blue_on);
        int   frame_clks;
        int   lines;
        int   run;
        int   hs_gap;
        logic hs_seen;
        logic de_q;
        logic hs_q;
        logic vs_q;
        logic done;
        rgb_t expected;
        frame_clks = 0;
        lines      = 0;
        run        = 0;
        hs_gap     = 0;
        hs_seen    = 1'b0;
        done       = 1'b0;
        de_q       = lcd_de;
        hs_q       = lcd_hs;
        vs_q       = lcd_vs;
        while (!done)
        begin
            @(negedge clk);
            frame_clks++;
            hs_gap++;

            if (check_colour)
            begin
                expected = '0;
                if (lcd_de)
                    expected = expected_pixel(run, lines, blue_on);
                check_value({name, " pixel"}, expected, {lcd_r, lcd_g, lcd_b});
            end

            // Column and row follow from the count of de clocks
            if (lcd_de)
            begin
                run++;
            end
            else if (de_q)
            begin
                check_value({name, " line width"}, screen_width, run);
                lines++;
                run = 0;
            end

            if (sync_starts(hs_q, lcd_hs))
            begin
                if (hs_seen)
                    check_value({name, " line total"}, h_total, hs_gap);
                hs_seen = 1'b1;
                hs_gap  = 0;
            end

            done = sync_starts(vs_q, lcd_vs);
            de_q = lcd_de;
            hs_q = lcd_hs;
            vs_q = lcd_vs;
        end
        check_value({name, " active lines"}, screen_height, lines);
        check_value({name, " frame total"}, frame_clocks, frame_clks);
    endtask

    //------------------------------------------------------------------------
    // I2S receiver

    task automatic align_i2s_decoder();
        bck_prev = hp_bck;
        ws_prev  = hp_ws;
        i2s_acc  = '0;
    endtask

    // Word ends with the bit taken on the first rising bck after ws moves
    task automatic read_i2s_frame(output sample_t left, output sample_t right);
        logic done;
        done  = 1'b0;
        left  = '0;
        right = '0;
        while (!done)
        begin
            @(negedge clk);
            if (hp_bck && !bck_prev)
            begin
                i2s_acc = {i2s_acc[14:0], hp_din};
                if (hp_ws != ws_prev)
                begin
                    if (ws_prev)
                    begin
                        right = i2s_acc;
                        done  = 1'b1;
                    end
                    else
                    begin
                        left = i2s_acc;
                    end
                end
                ws_prev = hp_ws;
            end
            bck_prev = hp_bck;
        end
    endtask

    //------------------------------------------------------------------------
    // Directed tests

    task automatic reset_and_check_idle();
        int i;
        rst_n = 1'b0;
        for (i = 0; i < reset_cycles; i++)
        begin
            @(negedge clk);
            check_idle_outputs("reset_state during");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs("reset_state after");
    endtask

    task automatic follow_tone_sequence();
        sample_t left;
        sample_t right;
        sample_t expected;
        int      skipped;
        int      k;
        align_i2s_decoder();
        skipped = 0;
        read_i2s_frame(left, right);
        check_value("audio_tone left_right", left, right);
        while (left == 0)
        begin
            skipped++;
            if (skipped > 4)
                fail_run("Audio output stayed silent for too many frames after reset");
            read_i2s_frame(left, right);
            check_value("audio_tone left_right", left, right);
        end
        for (k = 0; k < tone_frames; k++)
        begin
            if (k > 0)
            begin
                read_i2s_frame(left, right);
                check_value("audio_tone left_right", left, right);
            end
            expected = ((k / tone_half_period) % 2 == 0) ? tone_amplitude
                                                         : -tone_amplitude;
            check_value("audio_tone sample", expected, left);
        end
    endtask

    task automatic count_heartbeat_ticks();
        int i;
        for (i = 0; i < heartbeat_cycles; i++)
        begin
            @(negedge clk);
            check_value("heartbeat", (cycles_since_reset / tick_clocks) % (1 << w_led),
                        led);
        end
    endtask

    task automatic measure_scan_geometry();
        wait_vs_start();
        walk_frame("scan_geometry", 1'b0, 1'b0);
    endtask

    task automatic verify_pixel_colours();
        walk_frame("pixel_colour", 1'b1, 1'b0);
    endtask

    task automatic hold_blue_key();
        key[0] = 1'b0;
        wait_vs_start();
        wait_vs_start();
        walk_frame("key0_blue", 1'b1, 1'b1);
        key[0] = 1'b1;
    endtask

    task automatic hold_mute_key();
        sample_t left;
        sample_t right;
        int      frame;
        logic    muted;
        align_i2s_decoder();
        // First frame may be partial
        read_i2s_frame(left, right);
        key[1] = 1'b0;
        muted  = 1'b0;
        frame  = 0;
        while (!muted)
        begin
            read_i2s_frame(left, right);
            frame++;
            check_value("key1_mute left_right", left, right);
            if (left == 0)
                muted = 1'b1;
            else if (frame >= mute_frames)
                check_value("key1_mute silence", 0, left);
        end
        for (frame = 0; frame < 2; frame++)
        begin
            read_i2s_frame(left, right);
            check_value("key1_mute hold", 0, left);
            check_value("key1_mute hold", 0, right);
        end
        key[1] = 1'b1;
    endtask

    //------------------------------------------------------------------------
    // Main sequence and watchdog

    initial
    begin
        rst_n    = 1'b0;
        key      = 2'b11;
        bck_prev = 1'b0;
        ws_prev  = 1'b0;
        i2s_acc  = '0;

        reset_and_check_idle();
        // Audio goes first so the tone is seen from its positive start
        follow_tone_sequence();
        count_heartbeat_ticks();
        measure_scan_geometry();
        verify_pixel_colours();
        hold_blue_key();
        hold_mute_key();

        $display("Done: no errors");
        $finish;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        fail_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                           watchdog_cycles));
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
hw/video_pkg.sv
hw/audio_pkg.sv
hw/heartbeat_counter.sv
hw/lcd_timing.sv
hw/pattern_pixel_stage.sv
hw/tone_gen.sv
hw/i2s_audio_out.sv
hw/board_specific_top.sv
tb/tb_clock.sv
tb/board_tb.sv

//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP        = board_tb
RTL_TOP    = board_specific_top
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
